/* verification/lsuPatterns.txt */
# name op(1 write, 2 read) size(funct3) atom(0 none, 1 lr, 2 sc) bigEndian addr wdata
# then expRead, expFaults (bit 0 load, bit 1 store) and expSquash, all numbers in hex
swInit       1 2 0 0 100 11223344 00000000 0 0
lwWord       2 2 0 0 100 00000000 11223344 0 0
shUpper      1 1 0 0 102 0000aabb 00000000 0 0
lwAfterSh    2 2 0 0 100 00000000 aabb3344 0 0
swSigned     1 2 0 0 104 80f17f02 00000000 0 0
lbPos        2 0 0 0 105 00000000 0000007f 0 0
lbNeg        2 0 0 0 106 00000000 fffffff1 0 0
lbuNeg       2 4 0 0 107 00000000 00000080 0 0
lhNeg        2 1 0 0 106 00000000 ffff80f1 0 0
lhuNeg       2 5 0 0 106 00000000 000080f1 0 0
lhPos        2 1 0 0 104 00000000 00007f02 0 0
lwBig        2 2 0 1 100 00000000 4433bbaa 0 0
lbuBig       2 4 0 1 101 00000000 000000bb 0 0
swZero       1 2 0 0 108 00000000 00000000 0 0
sbBig        1 0 0 1 108 0000005a 00000000 0 0
lwAfterSbBig 2 2 0 0 108 00000000 5a000000 0 0
swMisaligned 1 2 0 0 101 deadbeef 00000000 2 0
shOdd        1 1 0 0 103 00001234 00000000 2 0
lwMisaligned 2 2 0 0 102 00000000 00000000 1 0
lhOdd        2 1 0 0 105 00000000 00000000 1 0
lwAfterFault 2 2 0 0 100 00000000 aabb3344 0 0
lrWord       2 2 1 0 100 00000000 aabb3344 0 0
scMatch      1 2 2 0 100 cafef00d 00000000 0 0
lwAfterSc    2 2 0 0 100 00000000 cafef00d 0 0
scAgain      1 2 2 0 100 0badf00d 00000000 0 1
lwKeepsOld   2 2 0 0 100 00000000 cafef00d 0 0
lrOther      2 2 1 0 104 00000000 80f17f02 0 0
scOtherWord  1 2 2 0 100 12345678 00000000 0 1
lwStillOld   2 2 0 0 100 00000000 cafef00d 0 0
scNoRes      1 2 2 0 104 00000055 00000000 0 1
lwNoResOld   2 2 0 0 104 00000000 80f17f02 0 0

/* list.f */
+incdir+include
+incdir+verification
hw/lsuPkg.sv
hw/accessCheck.sv
hw/lrscReservation.sv
hw/storeFormatter.sv
hw/dtim.sv
hw/loadFormatter.sv
hw/lsu.sv
verification/lsuTb.sv

/* Makefile */
TOP := lsuTb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f hw/*.sv include/*.svh verification/*.sv verification/*.svh
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "No errors" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module lsu -f list.f

clean:
	rm -rf obj_dir $(LOG)

/* verification/lsuChecks.svh */
// Checks for the LSU testbench, included inside the testbench module body
// The first failing check ends the run
`ifndef LSU_CHECKS_SVH
`define LSU_CHECKS_SVH

int errorCount = 0;                                      // Failing checks so far

//////////////////////////////////////////////////
// Failure exit
//////////////////////////////////////////////////

task automatic stopOnError();
  errorCount++;
  $display("Errors found");
  $fatal(1, "Stopped at the first failing check");
endtask

//////////////////////////////////////////////////
// Value compare
//////////////////////////////////////////////////

// X or Z from the DUT counts as a mismatch
task automatic checkValue(
  input string       testName,                           // Pattern line name
  input string       what,                               // Signal being checked
  input logic [31:0] expected,
  input logic [31:0] actual
);
  assert (actual === expected) else begin
    $display("Mismatch %s %s expected %h actual %h", testName, what, expected, actual);
    stopOnError();
  end
endtask

//////////////////////////////////////////////////
// Reset handling
//////////////////////////////////////////////////

// Polls rstN once per clock for at most maxCycles clocks
task automatic waitResetRelease(input int maxCycles);
  int cycles;
  cycles = 0;
  while (rstN !== 1'b1 && cycles < maxCycles) begin
    @(posedge clk);
    cycles++;
  end
  assert (rstN === 1'b1) else begin
    $display("Reset was still asserted after %0d cycles", maxCycles);
    stopOnError();
  end
endtask

// Registered outputs are cleared while reset is held
task automatic checkResetState();
  @(posedge clk);                                        // First edge with reset low
  @(negedge clk);                                        // Mid-cycle when outputs have settled
  checkValue("reset", "ReadDataW", 32'h0, ReadDataW);
  checkValue("reset", "SquashSCW", 32'h0, {31'b0, SquashSCW});
  checkValue("reset", "faults", 32'h0,
             {30'b0, StoreAmoMisalignedFaultM, LoadMisalignedFaultM});
endtask

`endif

/* verification/lsuTb.sv */
// Runs the pattern file one operation at a time through E, M and W cycles
// Stalls and flushes stay low and an idle slot follows every store
`timescale 1ns/1ps
`include "lsuSettings.svh"

module lsuTb;
  import lsuPkg::*;

  localparam int clkPeriod   = 20;                        // ns
  localparam int resetCycles = 8;
  localparam int maxLines    = 200;                       // Bound on pattern file lines

  logic                 clk;
  logic                 rstN;
  logic                 StallM;
  logic                 FlushM;
  logic                 StallW;
  logic                 FlushW;
  logic [`LSU_XLEN-1:0] IEUAdrE;
  memRwT                MemRWM;
  sizeT                 Funct3M;
  atomicT               AtomicM;
  logic [`LSU_XLEN-1:0] WriteDataM;
  logic                 BigEndianM;
  logic [`LSU_XLEN-1:0] IEUAdrM;
  logic [`LSU_XLEN-1:0] ReadDataW;
  logic                 SquashSCW;
  logic                 LoadMisalignedFaultM;
  logic                 StoreAmoMisalignedFaultM;

  int opCount = 0;                                        // Operations run

  `include "lsuChecks.svh"

  //////////////////////////////////////////////////
  // Clock, reset and DUT
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;                                          // Released 1 ns after the edge
  end

  lsu dut (
    .clk, .rstN, .StallM, .FlushM, .StallW, .FlushW,
    .IEUAdrE, .MemRWM, .Funct3M, .AtomicM, .WriteDataM, .BigEndianM,
    .IEUAdrM, .ReadDataW, .SquashSCW,
    .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM
  );

  //////////////////////////////////////////////////
  // Driver
  //////////////////////////////////////////////////

  // Bubble in the memory stage
  task automatic driveIdleM();
    MemRWM     = rwNone;
    Funct3M    = sizeW;
    AtomicM    = atomNone;
    WriteDataM = '0;
    BigEndianM = 1'b0;
  endtask

  task automatic runOp(
    input string       name,
    input logic [31:0] op,                                // memRwT code
    input logic [31:0] size,                              // funct3
    input logic [31:0] atom,                              // atomicT code
    input logic [31:0] be,
    input logic [31:0] addr,
    input logic [31:0] wdata,
    input logic [31:0] expRead,
    input logic [31:0] expFaults,                         // Bit 0 load and bit 1 store
    input logic [31:0] expSquash
  );
    memRwT rw;
    logic  expectData;
    rw         = memRwT'(op[1:0]);
    expectData = (rw == rwRead) && (expFaults == 0);      // Faulting load has no result
    @(posedge clk);                                       // Execute cycle
    #1;
    IEUAdrE = addr;
    driveIdleM();
    @(posedge clk);                                       // Memory cycle
    #1;
    IEUAdrE    = '0;
    MemRWM     = rw;
    Funct3M    = sizeT'(size[2:0]);
    AtomicM    = atomicT'(atom[1:0]);
    WriteDataM = wdata;
    BigEndianM = be[0];
    @(negedge clk);
    checkValue(name, "IEUAdrM", addr, IEUAdrM);
    checkValue(name, "faults", expFaults,
               {30'b0, StoreAmoMisalignedFaultM, LoadMisalignedFaultM});
    @(posedge clk);                                       // Writeback cycle
    #1;
    driveIdleM();
    @(negedge clk);
    if (expectData) checkValue(name, "ReadDataW", expRead, ReadDataW);
    checkValue(name, "SquashSCW", expSquash, {31'b0, SquashSCW});
    if (rw == rwWrite) begin                              // No hazard unit behind a store
      @(posedge clk);
      #1;
      driveIdleM();
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int          fd;
    int          n;
    int          lineCount;
    string       line;
    string       name;
    logic [31:0] op;
    logic [31:0] size;
    logic [31:0] atom;
    logic [31:0] be;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] expRead;
    logic [31:0] expFaults;
    logic [31:0] expSquash;
    StallM  = 1'b0;
    FlushM  = 1'b0;
    StallW  = 1'b0;
    FlushW  = 1'b0;
    IEUAdrE = '0;
    driveIdleM();
    checkResetState();
    waitResetRelease(4 * resetCycles);
    fd = $fopen("verification/lsuPatterns.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open the pattern file");
      stopOnError();
    end
    lineCount = 0;
    while (lineCount < maxLines && $fgets(line, fd) > 0) begin
      lineCount++;
      if (line.substr(0, 0) == "#") continue;             // Column notes
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", name, op, size, atom, be,
                  addr, wdata, expRead, expFaults, expSquash);
      if (n <= 0) continue;                               // Blank line
      assert (n == 10) else begin
        $display("Pattern line %0d has %0d fields instead of 10", lineCount, n);
        stopOnError();
      end
      runOp(name, op, size, atom, be, addr, wdata, expRead, expFaults, expSquash);
      opCount++;
    end
    $fclose(fd);
    assert (opCount > 0) else begin
      $display("The pattern file held no operations");
      stopOnError();
    end
    if (errorCount == 0) begin
      $display("No errors");
      $finish;
    end else begin
      stopOnError();
    end
  end

endmodule

/* hw/lsu.sv */
// DTIM-only load/store unit, no cache, bus, MMU or misaligned support
// The CPU must leave one idle slot after each store, there is no hazard check
`timescale 1ns/1ps
`include "lsuSettings.svh"

module lsu (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 StallM,
  input  logic                 FlushM,
  input  logic                 StallW,
  input  logic                 FlushW,
  input  logic [`LSU_XLEN-1:0] IEUAdrE,                  // Execute stage address
  input  lsuPkg::memRwT        MemRWM,                   // Read/write control
  input  lsuPkg::sizeT         Funct3M,                  // Size of access
  input  lsuPkg::atomicT       AtomicM,                  // LR/SC
  input  logic [`LSU_XLEN-1:0] WriteDataM,               // Store data from the IEU
  input  logic                 BigEndianM,               // Big-endian data access
  output logic [`LSU_XLEN-1:0] IEUAdrM,                  // Memory stage address
  output logic [`LSU_XLEN-1:0] ReadDataW,                // Load result
  output logic                 SquashSCW,                // Failed SC
  output logic                 LoadMisalignedFaultM,
  output logic                 StoreAmoMisalignedFaultM
);
  import lsuPkg::*;

  memRwT                  CheckedRWM;                    // Request after fault check
  memRwT                  LSURWM;                        // Request after LR/SC check
  logic [`LSU_XLEN-1:0]   StoreDataM;
  logic [`LSU_XLEN/8-1:0] ByteMaskM;
  logic [`LSU_XLEN-1:0]   ReadWordM;                     // Raw DTIM word

  //////////////////////////////////////////////////
  // Address register and alignment check
  //////////////////////////////////////////////////

  accessCheck accessCheck (
    .clk, .rstN, .StallM, .FlushM,
    .IEUAdrE, .IEUAdrM,
    .MemRWM, .Funct3M,
    .CheckedRWM,
    .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM
  );

  //////////////////////////////////////////////////
  // LR/SC reservation
  //////////////////////////////////////////////////

  lrscReservation lrscReservation (
    .clk, .rstN, .StallW, .FlushW,
    .IEUAdrM, .CheckedRWM, .AtomicM,
    .LSURWM, .SquashSCW
  );

  //////////////////////////////////////////////////
  // Store path, DTIM and load path
  //////////////////////////////////////////////////

  storeFormatter storeFormatter (
    .IEUAdrM, .Funct3M, .WriteDataM, .BigEndianM,
    .StoreDataM, .ByteMaskM
  );

  dtim dtim (
    .clk, .StallW, .FlushW,
    .IEUAdrE, .IEUAdrM, .LSURWM,
    .StoreDataM, .ByteMaskM,
    .ReadWordM
  );

  loadFormatter loadFormatter (
    .clk, .rstN, .StallW,
    .ReadWordM, .IEUAdrM, .Funct3M, .BigEndianM,
    .ReadDataW
  );

endmodule

/* hw/loadFormatter.sv */
// Swap comes before subword selection, so big-endian offset k reads byte 3-k
// ReadDataW is only meaningful in the cycle after a load's memory cycle
`timescale 1ns/1ps
`include "lsuSettings.svh"

module loadFormatter (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 StallW,                   // Hold writeback stage
  input  logic [`LSU_XLEN-1:0] ReadWordM,                // Raw word from the DTIM
  input  logic [`LSU_XLEN-1:0] IEUAdrM,                  // Offset within the word
  input  lsuPkg::sizeT         Funct3M,                  // Size and extension
  input  logic                 BigEndianM,
  output logic [`LSU_XLEN-1:0] ReadDataW                 // Result to writeback
);
  import lsuPkg::*;

  logic [`LSU_XLEN-1:0] swapWordM;                       // Byte-reversed word
  logic [`LSU_XLEN-1:0] wordM;                           // Word in hart byte order
  logic [7:0]           byteM;
  logic [15:0]          halfM;
  logic [`LSU_XLEN-1:0] readDataM;                       // Formatted result

  //////////////////////////////////////////////////
  // Endian swap
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `LSU_XLEN/8; i++) begin
      swapWordM[8*i +: 8] = ReadWordM[`LSU_XLEN-8-8*i +: 8];
    end
  end

  assign wordM = BigEndianM ? swapWordM : ReadWordM;

  //////////////////////////////////////////////////
  // Subword select and extension
  //////////////////////////////////////////////////

  assign byteM = wordM[{IEUAdrM[1:0], 3'b000} +: 8];     // Byte lane
  assign halfM = wordM[{IEUAdrM[1], 4'b0000} +: 16];     // Halfword lane

  always_comb begin
    case (Funct3M)
      sizeB:   readDataM = {{(`LSU_XLEN-8){byteM[7]}}, byteM};
      sizeH:   readDataM = {{(`LSU_XLEN-16){halfM[15]}}, halfM};
      sizeBU:  readDataM = {{(`LSU_XLEN-8){1'b0}}, byteM};
      sizeHU:  readDataM = {{(`LSU_XLEN-16){1'b0}}, halfM};
      default: readDataM = wordM;                        // LW and LR
    endcase
  end

  // M to W read data register
  always_ff @(posedge clk) begin
    if (!rstN) ReadDataW <= '0;
    else if (!StallW) ReadDataW <= readDataM;
  end

endmodule

/* hw/dtim.sv */
// Word-wide memory with byte enables, contents are not reset
// Only address bits 9:2 are decoded so the array aliases above 1 KiB
`timescale 1ns/1ps
`include "lsuSettings.svh"

module dtim (
  input  logic                   clk,
  input  logic                   StallW,                 // Freezes read and write
  input  logic                   FlushW,                 // Cancels the store in M
  input  logic [`LSU_XLEN-1:0]   IEUAdrE,                // Read address, one cycle early
  input  logic [`LSU_XLEN-1:0]   IEUAdrM,                // Write address
  input  lsuPkg::memRwT          LSURWM,                 // Final request
  input  logic [`LSU_XLEN-1:0]   StoreDataM,
  input  logic [`LSU_XLEN/8-1:0] ByteMaskM,
  output logic [`LSU_XLEN-1:0]   ReadWordM               // Word for the load in M
);
  import lsuPkg::*;

  logic [`LSU_XLEN-1:0]      mem [`DTIM_WORDS];
  logic [`DTIM_ADR_BITS-1:0] dtimAdr;
  logic                      writeM;
  logic                      ce;                         // Clock enable

  assign writeM = (LSURWM == rwWrite);
  assign ce     = ~StallW;

  // Store uses M address, otherwise read ahead with E address
  assign dtimAdr = writeM ? IEUAdrM[`DTIM_ADR_BITS+1:2] : IEUAdrE[`DTIM_ADR_BITS+1:2];

  always_ff @(posedge clk) begin
    if (ce) begin
      ReadWordM <= mem[dtimAdr];                         // Registered read
      if (writeM && !FlushW) begin
        for (int i = 0; i < `LSU_XLEN/8; i++) begin
          if (ByteMaskM[i]) mem[dtimAdr][8*i +: 8] <= StoreDataM[8*i +: 8];
        end
      end
    end
  end

endmodule

/* hw/storeFormatter.sv */
// Store data is replicated across the word, the byte mask picks the lanes
// Big-endian swaps the whole word, so offset k lands in memory byte 3-k
`timescale 1ns/1ps
`include "lsuSettings.svh"

module storeFormatter (
  input  logic [`LSU_XLEN-1:0]   IEUAdrM,                // Low bits pick the lanes
  input  lsuPkg::sizeT           Funct3M,                // Store size
  input  logic [`LSU_XLEN-1:0]   WriteDataM,             // Data from the IEU
  input  logic                   BigEndianM,
  output logic [`LSU_XLEN-1:0]   StoreDataM,             // Data to the DTIM
  output logic [`LSU_XLEN/8-1:0] ByteMaskM               // Byte write enables
);
  import lsuPkg::*;

  logic [`LSU_XLEN-1:0]   leDataM;                       // Little-endian store word
  logic [`LSU_XLEN/8-1:0] leMaskM;
  logic [`LSU_XLEN-1:0]   beDataM;                       // Byte-reversed word
  logic [`LSU_XLEN/8-1:0] beMaskM;

  // Replicate subword so every lane carries it
  always_comb begin
    case (Funct3M)
      sizeB, sizeBU: leDataM = {(`LSU_XLEN/8){WriteDataM[7:0]}};
      sizeH, sizeHU: leDataM = {(`LSU_XLEN/16){WriteDataM[15:0]}};
      default:       leDataM = WriteDataM;
    endcase
  end

  // Mask from size and offset
  always_comb begin
    case (Funct3M)
      sizeB, sizeBU: leMaskM = {{(`LSU_XLEN/8-1){1'b0}}, 1'b1} << IEUAdrM[1:0];
      sizeH, sizeHU: leMaskM = {{(`LSU_XLEN/8-2){1'b0}}, 2'b11} << {IEUAdrM[1], 1'b0};
      default:       leMaskM = '1;                       // Full word
    endcase
  end

  // Reverse bytes and mask lanes together
  always_comb begin
    for (int i = 0; i < `LSU_XLEN/8; i++) begin
      beDataM[8*i +: 8] = leDataM[`LSU_XLEN-8-8*i +: 8];
      beMaskM[i]        = leMaskM[`LSU_XLEN/8-1-i];
    end
  end

  assign StoreDataM = BigEndianM ? beDataM : leDataM;
  assign ByteMaskM  = BigEndianM ? beMaskM : leMaskM;

endmodule

/* hw/lrscReservation.sv */
// Single reservation on a 32-bit word, no timeout on the reservation
// A flushed LR or SC leaves the reservation untouched
`timescale 1ns/1ps
`include "lsuSettings.svh"

module lrscReservation (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 StallW,                   // Hold writeback stage
  input  logic                 FlushW,                   // Kill instruction leaving M
  input  logic [`LSU_XLEN-1:0] IEUAdrM,                  // Memory stage address
  input  lsuPkg::memRwT        CheckedRWM,               // Request after fault check
  input  lsuPkg::atomicT       AtomicM,                  // LR/SC marker
  output lsuPkg::memRwT        LSURWM,                   // Request to memory
  output logic                 SquashSCW                 // SC failed, no GPR write of 0
);
  import lsuPkg::*;

  logic                 resValidW;                       // Reservation held
  logic [`LSU_XLEN-3:0] resAdrW;                         // Reserved word address
  logic                 lrM;
  logic                 scM;
  logic                 scMatchM;                        // SC hits the reservation
  logic                 squashSCM;
  logic                 updateM;                         // Instruction really leaves M

  assign lrM       = (CheckedRWM == rwRead) & (AtomicM == atomLr);
  assign scM       = (CheckedRWM == rwWrite) & (AtomicM == atomSc);
  assign scMatchM  = resValidW & (IEUAdrM[`LSU_XLEN-1:2] == resAdrW);
  assign squashSCM = scM & ~scMatchM;
  assign updateM   = ~StallW & ~FlushW;

  assign LSURWM = squashSCM ? rwNone : CheckedRWM;       // Failed SC never writes

  // Valid bit, set by LR and cleared by any SC
  always_ff @(posedge clk) begin
    if (!rstN) begin
      resValidW <= 1'b0;
    end else if (updateM) begin
      if (lrM) resValidW <= 1'b1;
      else if (scM) resValidW <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (lrM && updateM) resAdrW <= IEUAdrM[`LSU_XLEN-1:2];  // Word granule
  end

  // Squash travels with the SC into writeback
  always_ff @(posedge clk) begin
    if (!rstN || FlushW) SquashSCW <= 1'b0;
    else if (!StallW) SquashSCW <= squashSCM;
  end

endmodule

/* hw/accessCheck.sv */
// Only natural alignment is accepted, there is no misaligned access support
// A faulting request is turned into rwNone before it can reach memory
`timescale 1ns/1ps
`include "lsuSettings.svh"

module accessCheck (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 StallM,                   // Hold memory stage
  input  logic                 FlushM,                   // Bubble into memory stage
  input  logic [`LSU_XLEN-1:0] IEUAdrE,                  // Execute stage address
  output logic [`LSU_XLEN-1:0] IEUAdrM,                  // Memory stage address
  input  lsuPkg::memRwT        MemRWM,                   // Request from the pipeline
  input  lsuPkg::sizeT         Funct3M,                  // Access size
  output lsuPkg::memRwT        CheckedRWM,               // Request with faults removed
  output logic                 LoadMisalignedFaultM,
  output logic                 StoreAmoMisalignedFaultM
);
  import lsuPkg::*;

  logic misalignedM;                                     // Address not aligned to size

  // E to M address register, flush only takes effect when the stage moves
  always_ff @(posedge clk) begin
    if (!rstN) begin
      IEUAdrM <= '0;
    end else if (!StallM) begin
      if (FlushM) IEUAdrM <= '0;                         // Bubble
      else IEUAdrM <= IEUAdrE;
    end
  end

  // Alignment from size and low address bits
  always_comb begin
    case (Funct3M)
      sizeH, sizeHU: misalignedM = IEUAdrM[0];           // Odd halfword
      sizeW:         misalignedM = |IEUAdrM[1:0];        // Word not on 4-byte boundary
      default:       misalignedM = 1'b0;                 // Bytes never fault
    endcase
  end

  // Fault type follows the direction of the request
  assign LoadMisalignedFaultM     = misalignedM & (MemRWM == rwRead);
  assign StoreAmoMisalignedFaultM = misalignedM & (MemRWM == rwWrite);

  assign CheckedRWM = misalignedM ? rwNone : MemRWM;     // Drop faulting access

endmodule

/* hw/lsuPkg.sv */
// Shared enums for the load/store unit
// Size codes follow the RISC-V funct3 field of loads and stores
package lsuPkg;

  // Memory request, bit 0 means write and bit 1 means read
  typedef enum logic [1:0] {
    rwNone  = 2'b00,         // No access
    rwWrite = 2'b01,         // Store or SC
    rwRead  = 2'b10          // Load or LR
  } memRwT;

  // Access size and extension, same bits as funct3
  typedef enum logic [2:0] {
    sizeB  = 3'b000,         // Byte, sign-extended
    sizeH  = 3'b001,         // Halfword, sign-extended
    sizeW  = 3'b010,         // Word
    sizeBU = 3'b100,         // Byte, zero-extended
    sizeHU = 3'b101          // Halfword, zero-extended
  } sizeT;

  // Atomic operation carried with the request
  typedef enum logic [1:0] {
    atomNone = 2'b00,        // Plain load or store
    atomLr   = 2'b01,        // Load-reserved
    atomSc   = 2'b10         // Store-conditional
  } atomicT;

endpackage

/* include/lsuSettings.svh */
// Word width and DTIM geometry for the load/store unit
// Higher addresses alias because the DTIM decodes only the word index
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

`define LSU_XLEN 32          // Data and address width, XLEN = LLEN

//////////////////////////////////////////////////
// DTIM geometry
//////////////////////////////////////////////////

`define DTIM_WORDS 256       // Number of 32-bit words
`define DTIM_ADR_BITS 8      // Word index, taken from address bits 9:2

`endif
